//--- arvi_core.f
design/arvi_pkg.sv
design/main_control.sv
design/reg_file.sv
design/imm_gen.sv
design/alu.sv
design/load_store_unit.sv
design/pc_unit.sv
design/arvi_core.sv
dv/arvi_core_checker.sv
dv/arvi_core_tb.sv

//--- Bender.yml
package:
  name: arvi_core

sources:
  - design/arvi_pkg.sv
  - design/main_control.sv
  - design/reg_file.sv
  - design/imm_gen.sv
  - design/alu.sv
  - design/load_store_unit.sv
  - design/pc_unit.sv
  - design/arvi_core.sv
  - target: test
    files:
      - dv/arvi_core_checker.sv
      - dv/arvi_core_tb.sv

//--- dv/arvi_core_tb.sv
// arvi_core_tb: instruction and data memory models, program table with expected results, checks
`timescale 1ns/10ps

module arvi_core_tb;
	import arvi_pkg::*;

	typedef enum {row_plain, row_store, row_load, row_flow, row_skip} row_kind_t;

	logic    i_clk;
	logic    i_rst;
	word_t   i_instr;
	word_t   o_pc;
	word_t   o_dm_addr;
	word_t   o_dm_wdata;
	strobe_t o_dm_strb;
	logic    o_dm_we;
	logic    o_dm_re;
	word_t   i_dm_rdata;
	logic    i_dm_ready;

	// Program table, one row per word of instruction memory
	word_t     rom_instr [64];
	string     row_name [64];
	row_kind_t row_kind [64];
	word_t     row_addr [64];
	strobe_t   row_strb [64];
	word_t     row_data [64];
	int        n_rows;

	word_t       dmem [64];
	logic        fetch_en;
	logic        mem_busy;
	int          mem_wait;
	int unsigned rand_state;
	int          mismatch_count;
	int          timeout_count;
	int          assertion_count;
	bit          timed_out;
	int          wait_limit = 40;

	arvi_core dut0 (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_instr    (i_instr),
		.o_pc       (o_pc),
		.o_dm_addr  (o_dm_addr),
		.o_dm_wdata (o_dm_wdata),
		.o_dm_strb  (o_dm_strb),
		.o_dm_we    (o_dm_we),
		.o_dm_re    (o_dm_re),
		.i_dm_rdata (i_dm_rdata),
		.i_dm_ready (i_dm_ready)
	);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic word_t i_type(logic [6:0] op, logic [4:0] rd, logic [2:0] f3,
		logic [4:0] rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t s_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
	endfunction

	function automatic word_t b_type(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
	endfunction

	function automatic word_t u_type(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic word_t j_type(logic [4:0] rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	// LCG for the data memory answer delay
	function automatic int unsigned next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return rand_state >> 16;
	endfunction

	// Combinational fetch, NOP during reset and past the program
	assign i_instr = (fetch_en && (o_pc < word_t'(n_rows * 4))) ? rom_instr[o_pc[7:2]]
		: i_type(op_imm, 5'd0, 3'b000, 5'd0, 12'd0);

	// Data memory answers after 0 to 3 extra cycles, ready lasts one cycle
	always @(posedge i_clk) begin
		if (i_dm_ready) begin
			i_dm_ready <= 1'b0;
		end else if (o_dm_we || o_dm_re) begin
			if (!mem_busy) begin
				mem_busy <= 1'b1;
				mem_wait <= next_rand() % 4;
			end else if (mem_wait == 0) begin
				mem_busy   <= 1'b0;
				i_dm_ready <= 1'b1;
				i_dm_rdata <= dmem[o_dm_addr[7:2]];
				for (int b = 0; b < 4; b++) begin
					if (o_dm_we && o_dm_strb[b]) begin
						dmem[o_dm_addr[7:2]][8*b +: 8] <= o_dm_wdata[8*b +: 8];
					end
				end
			end else begin
				mem_wait <= mem_wait - 1;
			end
		end
	end

	task automatic append_row(word_t instr, string name, row_kind_t kind, word_t addr,
		strobe_t strb, word_t data);
		rom_instr[n_rows] = instr;
		row_name[n_rows]  = name;
		row_kind[n_rows]  = kind;
		row_addr[n_rows]  = addr;
		row_strb[n_rows]  = strb;
		row_data[n_rows]  = data;
		n_rows++;
	endtask

	task automatic plain_row(word_t instr, string name);
		append_row(instr, name, row_plain, '0, '0, '0);
	endtask

	task automatic store_row(word_t instr, string name, word_t addr, strobe_t strb, word_t data);
		append_row(instr, name, row_store, addr, strb, data);
	endtask

	// For loads, the address column holds the word address seen by memory
	task automatic load_row(word_t instr, string name, word_t addr);
		append_row(instr, name, row_load, addr, '0, '0);
	endtask

	// For control flow, the address column holds the next PC
	task automatic jump_row(word_t instr, string name, word_t target);
		append_row(instr, name, row_flow, target, '0, '0);
	endtask

	// Slots that a taken branch or jump must pass over
	task automatic skip_slots(int count);
		for (int k = 0; k < count; k++) begin
			append_row(i_type(op_imm, 5'd15, 3'b000, 5'd0, 12'h7ff), "skipped", row_skip,
				'0, '0, '0);
		end
	endtask

	task automatic build_program();
		n_rows = 0;
		store_row(s_type(3'b010, 5'd0, 5'd5, 12'h000), "sw_x5_zero", 32'h00, 4'b1111, 32'h0);
		plain_row(i_type(op_imm, 5'd1, 3'b000, 5'd0, 12'h123), "addi_x1");
		plain_row(i_type(op_imm, 5'd2, 3'b000, 5'd0, 12'hffb), "addi_x2");
		plain_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3), "add_x3");
		plain_row(r_type(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4), "sub_x4");
		plain_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b100, 5'd5), "xor_x5");
		plain_row(r_type(7'b0100000, 5'd1, 5'd5, 3'b101, 5'd6), "sra_x6");
		plain_row(r_type(7'b0000000, 5'd2, 5'd1, 3'b011, 5'd7), "sltu_x7");
		plain_row(u_type(op_lui, 5'd8, 20'h80f08), "lui_x8");
		plain_row(i_type(op_imm, 5'd8, 3'b000, 5'd8, 12'hf85), "addi_x8");
		plain_row(u_type(op_auipc, 5'd9, 20'h12345), "auipc_x9");
		store_row(s_type(3'b010, 5'd0, 5'd3, 12'h040), "sw_add", 32'h40, 4'b1111, 32'h11e);
		store_row(s_type(3'b010, 5'd0, 5'd4, 12'h044), "sw_sub", 32'h44, 4'b1111, 32'h128);
		store_row(s_type(3'b010, 5'd0, 5'd5, 12'h048), "sw_xor", 32'h48, 4'b1111, 32'hffff_fed8);
		store_row(s_type(3'b010, 5'd0, 5'd6, 12'h04c), "sw_sra", 32'h4c, 4'b1111, 32'hffff_ffdb);
		store_row(s_type(3'b010, 5'd0, 5'd7, 12'h050), "sw_sltu", 32'h50, 4'b1111, 32'h1);
		store_row(s_type(3'b010, 5'd0, 5'd9, 12'h054), "sw_auipc", 32'h54, 4'b1111, 32'h1234_5028);
		store_row(s_type(3'b010, 5'd0, 5'd8, 12'h060), "sw_lui", 32'h60, 4'b1111, 32'h80f0_7f85);
		store_row(s_type(3'b000, 5'd0, 5'd1, 12'h065), "sb_off1", 32'h64, 4'b0010, 32'h2323_2323);
		store_row(s_type(3'b000, 5'd0, 5'd2, 12'h067), "sb_off3", 32'h64, 4'b1000, 32'hfbfb_fbfb);
		store_row(s_type(3'b001, 5'd0, 5'd1, 12'h06a), "sh_off2", 32'h68, 4'b1100, 32'h0123_0123);
		store_row(s_type(3'b001, 5'd0, 5'd2, 12'h06c), "sh_off0", 32'h6c, 4'b0011, 32'hfffb_fffb);
		load_row(i_type(op_load, 5'd10, 3'b000, 5'd0, 12'h060), "lb_x10", 32'h60);
		store_row(s_type(3'b010, 5'd0, 5'd10, 12'h070), "sw_lb", 32'h70, 4'b1111, 32'hffff_ff85);
		load_row(i_type(op_load, 5'd11, 3'b100, 5'd0, 12'h062), "lbu_x11", 32'h60);
		store_row(s_type(3'b010, 5'd0, 5'd11, 12'h074), "sw_lbu", 32'h74, 4'b1111, 32'h0000_00f0);
		load_row(i_type(op_load, 5'd12, 3'b001, 5'd0, 12'h062), "lh_x12", 32'h60);
		store_row(s_type(3'b010, 5'd0, 5'd12, 12'h078), "sw_lh", 32'h78, 4'b1111, 32'hffff_80f0);
		load_row(i_type(op_load, 5'd13, 3'b101, 5'd0, 12'h060), "lhu_x13", 32'h60);
		store_row(s_type(3'b010, 5'd0, 5'd13, 12'h07c), "sw_lhu", 32'h7c, 4'b1111, 32'h0000_7f85);
		load_row(i_type(op_load, 5'd14, 3'b010, 5'd0, 12'h060), "lw_x14", 32'h60);
		store_row(s_type(3'b010, 5'd0, 5'd14, 12'h080), "sw_lw", 32'h80, 4'b1111, 32'h80f0_7f85);
		// Taken branches skip one slot
		jump_row(b_type(3'b000, 5'd1, 5'd1, 13'd8), "beq_taken", 32'd136);
		skip_slots(1);
		jump_row(b_type(3'b001, 5'd1, 5'd2, 13'd8), "bne_taken", 32'd144);
		skip_slots(1);
		jump_row(b_type(3'b100, 5'd2, 5'd1, 13'd8), "blt_taken", 32'd152);
		skip_slots(1);
		jump_row(b_type(3'b101, 5'd1, 5'd2, 13'd8), "bge_taken", 32'd160);
		skip_slots(1);
		jump_row(b_type(3'b110, 5'd1, 5'd2, 13'd8), "bltu_taken", 32'd168);
		skip_slots(1);
		jump_row(b_type(3'b111, 5'd2, 5'd1, 13'd8), "bgeu_taken", 32'd176);
		skip_slots(1);
		jump_row(b_type(3'b000, 5'd1, 5'd2, 13'd8), "beq_not_taken", 32'd180);
		jump_row(b_type(3'b001, 5'd1, 5'd1, 13'd8), "bne_not_taken", 32'd184);
		jump_row(b_type(3'b100, 5'd1, 5'd2, 13'd8), "blt_not_taken", 32'd188);
		jump_row(b_type(3'b101, 5'd2, 5'd1, 13'd8), "bge_not_taken", 32'd192);
		jump_row(b_type(3'b110, 5'd2, 5'd1, 13'd8), "bltu_not_taken", 32'd196);
		jump_row(b_type(3'b111, 5'd1, 5'd2, 13'd8), "bgeu_not_taken", 32'd200);
		jump_row(j_type(5'd16, 21'd12), "jal_x16", 32'd212);
		skip_slots(2);
		// 204 + 25 has bit 0 set, cleared for the target
		jump_row(i_type(op_jalr, 5'd17, 3'b000, 5'd16, 12'd25), "jalr_x17", 32'd228);
		skip_slots(3);
		store_row(s_type(3'b010, 5'd0, 5'd16, 12'h084), "sw_jal_link", 32'h84, 4'b1111, 32'd204);
		store_row(s_type(3'b010, 5'd0, 5'd17, 12'h088), "sw_jalr_link", 32'h88, 4'b1111, 32'd216);
		jump_row(j_type(5'd0, 21'd0), "jal_park", 32'd236);
	endtask

	task automatic compare_word(string name, word_t expected, word_t actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic compare_strb(string name, strobe_t expected, strobe_t actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic compare_bit(string name, logic expected, logic actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic report_timeout(string what);
		$display("Timeout: %s", what);
		timeout_count++;
		timed_out = 1'b1;
	endtask

	task automatic wait_pc(word_t pc, string name);
		int n;
		n = 0;
		while ((o_pc !== pc) && (n < wait_limit)) begin
			@(negedge i_clk);
			n++;
		end
		if (o_pc !== pc) begin
			report_timeout($sformatf("%s, the core never fetched from address %h", name, pc));
		end
	endtask

	task automatic wait_store(string name);
		int n;
		n = 0;
		while (!o_dm_we && (n < wait_limit)) begin
			@(negedge i_clk);
			n++;
		end
		if (!o_dm_we) begin
			report_timeout($sformatf("%s, no store request appeared", name));
		end
	endtask

	// PC must stay put until memory answers
	task automatic hold_until_ready(word_t pc, string name);
		int n;
		n = 0;
		while (!i_dm_ready && (n < wait_limit)) begin
			compare_word({name, " stall_pc"}, pc, o_pc);
			@(negedge i_clk);
			n++;
		end
		if (!i_dm_ready) begin
			report_timeout($sformatf("%s, data memory never raised ready", name));
		end
	endtask

	task automatic run_row(int i);
		word_t pc;
		pc = word_t'(i * 4);
		wait_pc(pc, row_name[i]);
		if (timed_out) begin
			return;
		end
		if (row_kind[i] == row_store) begin
			wait_store(row_name[i]);
			if (timed_out) begin
				return;
			end
			compare_word({row_name[i], " addr"}, row_addr[i], o_dm_addr);
			compare_strb({row_name[i], " strb"}, row_strb[i], o_dm_strb);
			compare_word({row_name[i], " data"}, row_data[i], o_dm_wdata);
		end
		// Only stores write and only loads read
		compare_bit({row_name[i], " we"}, row_kind[i] == row_store, o_dm_we);
		compare_bit({row_name[i], " re"}, row_kind[i] == row_load, o_dm_re);
		if (row_kind[i] == row_load) begin
			compare_word({row_name[i], " addr"}, row_addr[i], o_dm_addr);
		end
		if (o_dm_we || o_dm_re) begin
			hold_until_ready(pc, row_name[i]);
		end
		if (row_kind[i] == row_flow) begin
			@(negedge i_clk);
			compare_word({row_name[i], " next_pc"}, row_addr[i], o_pc);
		end
	endtask

	initial begin
		rand_state     = 60;
		mismatch_count = 0;
		timeout_count  = 0;
		timed_out      = 1'b0;
		i_rst          = 1'b0;
		fetch_en       = 1'b0;
		i_dm_ready     = 1'b0;
		i_dm_rdata     = '0;
		mem_busy       = 1'b0;
		mem_wait       = 0;
		for (int a = 0; a < 64; a++) begin
			dmem[a] = 32'hc3a5_0000 ^ (a * 32'h0103_0507);
		end
		build_program();
		repeat (3) @(posedge i_clk);
		i_rst    <= 1'b1;
		fetch_en <= 1'b1;
		@(negedge i_clk);
		compare_word("reset_pc", pc_reset, o_pc);
		for (int i = 0; (i < n_rows) && !timed_out; i++) begin
			if (row_kind[i] != row_skip) begin
				run_row(i);
			end
		end
		// Second reset, x5 holds a nonzero value by now
		if (!timed_out) begin
			@(posedge i_clk);
			i_rst    <= 1'b0;
			fetch_en <= 1'b0;
			repeat (3) @(posedge i_clk);
			i_rst    <= 1'b1;
			fetch_en <= 1'b1;
			@(negedge i_clk);
			compare_word("second_reset_pc", pc_reset, o_pc);
			run_row(0);
		end
		assertion_count = dut0.checker0.fail_count;
		$display("Mismatches: %0d, timeouts: %0d, assertion failures: %0d", mismatch_count,
			timeout_count, assertion_count);
		if ((mismatch_count == 0) && (timeout_count == 0) && (assertion_count == 0)) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- dv/arvi_core_checker.sv
// arvi_core_checker: bound assertions on request exclusivity, PC hold under stall and reset PC
`timescale 1ns/10ps

module arvi_core_checker (
	input logic            i_clk,
	input logic            i_rst,
	input arvi_pkg::word_t i_pc,
	input logic            i_dm_we,
	input logic            i_dm_re,
	input logic            i_dm_ready
);
	import arvi_pkg::*;

	// Number of failed assertions
	int unsigned fail_count = 0;

	// A single access is either a read or a write
	we_re_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst)
		!(i_dm_we && i_dm_re))
		else begin
			fail_count++;
			$error("Data memory read and write requested in the same cycle");
		end

	// Open request without ready keeps the PC where it is
	pc_hold_on_stall: assert property (@(posedge i_clk) disable iff (!i_rst)
		((i_dm_we || i_dm_re) && !i_dm_ready) |=> $stable(i_pc))
		else begin
			fail_count++;
			$error("PC moved while a data memory request was waiting for ready");
		end

	pc_after_reset: assert property (@(posedge i_clk) !i_rst |=> (i_pc == pc_reset))
		else begin
			fail_count++;
			$error("PC does not hold the reset value after a reset cycle");
		end

endmodule

bind arvi_core arvi_core_checker checker0 (
	.i_clk      (i_clk),
	.i_rst      (i_rst),
	.i_pc       (o_pc),
	.i_dm_we    (o_dm_we),
	.i_dm_re    (o_dm_re),
	.i_dm_ready (i_dm_ready)
);

//--- design/arvi_core.sv
// arvi_core: single-cycle RV32I core with operand and write-back multiplexers
`timescale 1ns/10ps

module arvi_core (
	input  logic              i_clk,
	input  logic              i_rst,
	input  arvi_pkg::word_t   i_instr,
	output arvi_pkg::word_t   o_pc,
	output arvi_pkg::word_t   o_dm_addr,
	output arvi_pkg::word_t   o_dm_wdata,
	output arvi_pkg::strobe_t o_dm_strb,
	output logic              o_dm_we,
	output logic              o_dm_re,
	input  arvi_pkg::word_t   i_dm_rdata,
	input  logic              i_dm_ready
);
	import arvi_pkg::*;

	alu_op_t alu_op;
	src_a_t  src_a;
	jump_t   jump;
	wb_sel_t wb_sel;
	logic    src_b_imm;
	logic    reg_write;
	logic    mem_read;
	logic    mem_write;
	logic    branch;
	logic    branch_taken;
	logic    stall;
	logic    rf_we;
	word_t   rdata1;
	word_t   rdata2;
	word_t   imm;
	word_t   alu_a;
	word_t   alu_b;
	word_t   alu_result;
	word_t   load_data;
	word_t   pc_plus4;
	word_t   wb_data;

	main_control u_main_control (
		.i_instr     (i_instr),
		.o_alu_op    (alu_op),
		.o_src_a     (src_a),
		.o_src_b_imm (src_b_imm),
		.o_reg_write (reg_write),
		.o_mem_read  (mem_read),
		.o_mem_write (mem_write),
		.o_branch    (branch),
		.o_jump      (jump),
		.o_wb_sel    (wb_sel)
	);

	// No register write until memory is ready
	assign rf_we = reg_write && !stall;

	reg_file u_reg_file (
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_rs1    (i_instr[19:15]),
		.i_rs2    (i_instr[24:20]),
		.i_rd     (i_instr[11:7]),
		.i_we     (rf_we),
		.i_wdata  (wb_data),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2)
	);

	imm_gen u_imm_gen (
		.i_instr (i_instr),
		.o_imm   (imm)
	);

	// Operand A: rs1, pc for auipc, zero for lui
	always_comb begin
		case (src_a)
			src_a_pc:   alu_a = o_pc;
			src_a_zero: alu_a = '0;
			default:    alu_a = rdata1;
		endcase
	end

	assign alu_b = src_b_imm ? imm : rdata2;

	alu u_alu (
		.i_a            (alu_a),
		.i_b            (alu_b),
		.i_op           (alu_op),
		.i_funct3       (i_instr[14:12]),
		.o_result       (alu_result),
		.o_branch_taken (branch_taken)
	);

	load_store_unit u_load_store_unit (
		.i_addr      (alu_result),
		.i_wdata     (rdata2),
		.i_funct3    (i_instr[14:12]),
		.i_mem_read  (mem_read),
		.i_mem_write (mem_write),
		.i_dm_rdata  (i_dm_rdata),
		.i_dm_ready  (i_dm_ready),
		.o_dm_addr   (o_dm_addr),
		.o_dm_wdata  (o_dm_wdata),
		.o_dm_strb   (o_dm_strb),
		.o_dm_we     (o_dm_we),
		.o_dm_re     (o_dm_re),
		.o_load_data (load_data),
		.o_stall     (stall)
	);

	pc_unit u_pc_unit (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_stall        (stall),
		.i_jump         (jump),
		.i_branch       (branch),
		.i_branch_taken (branch_taken),
		.i_imm          (imm),
		.i_alu_result   (alu_result),
		.o_pc           (o_pc),
		.o_pc_plus4     (pc_plus4)
	);

	// Write-back source
	always_comb begin
		case (wb_sel)
			wb_mem:      wb_data = load_data;
			wb_pc_plus4: wb_data = pc_plus4;
			default:     wb_data = alu_result;
		endcase
	end

endmodule

//--- design/pc_unit.sv
// pc_unit: program counter register and next-PC selection
`timescale 1ns/10ps

module pc_unit (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic            i_stall,
	input  arvi_pkg::jump_t i_jump,
	input  logic            i_branch,
	input  logic            i_branch_taken,
	input  arvi_pkg::word_t i_imm,
	input  arvi_pkg::word_t i_alu_result,
	output arvi_pkg::word_t o_pc,
	output arvi_pkg::word_t o_pc_plus4
);
	import arvi_pkg::*;

	word_t pc_q;
	word_t pc_next;

	assign o_pc       = pc_q;
	assign o_pc_plus4 = pc_q + 32'd4;

	always_comb begin
		if (i_jump == jump_jalr) begin
			pc_next = {i_alu_result[xlen-1:1], 1'b0};
		end else if ((i_jump == jump_jal) || (i_branch && i_branch_taken)) begin
			pc_next = pc_q + i_imm;
		end else begin
			pc_next = o_pc_plus4;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			pc_q <= pc_reset;
		end else if (!i_stall) begin
			pc_q <= pc_next;
		end
	end

endmodule

//--- design/load_store_unit.sv
// load_store_unit: store lane placement, byte enables, load extension and memory stall
`timescale 1ns/10ps

module load_store_unit (
	input  arvi_pkg::word_t   i_addr,
	input  arvi_pkg::word_t   i_wdata,
	input  logic [2:0]        i_funct3,
	input  logic              i_mem_read,
	input  logic              i_mem_write,
	input  arvi_pkg::word_t   i_dm_rdata,
	input  logic              i_dm_ready,
	output arvi_pkg::word_t   o_dm_addr,
	output arvi_pkg::word_t   o_dm_wdata,
	output arvi_pkg::strobe_t o_dm_strb,
	output logic              o_dm_we,
	output logic              o_dm_re,
	output arvi_pkg::word_t   o_load_data,
	output logic              o_stall
);
	import arvi_pkg::*;

	logic    [1:0] offset;
	logic          request;
	strobe_t       lane_strb;
	word_t         lane_data;

	assign offset    = i_addr[1:0];
	assign request   = i_mem_read || i_mem_write;
	assign o_dm_addr = {i_addr[xlen-1:2], 2'b00};
	assign o_dm_we   = i_mem_write;
	assign o_dm_re   = i_mem_read;

	// Store data repeated on every lane, strobe picks the live one
	always_comb begin
		case (i_funct3[1:0])
			2'b00: begin
				o_dm_wdata = {4{i_wdata[7:0]}};
				lane_strb  = 4'b0001 << offset;
			end
			2'b01: begin
				o_dm_wdata = {2{i_wdata[15:0]}};
				lane_strb  = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				o_dm_wdata = i_wdata;
				lane_strb  = 4'b1111;
			end
		endcase
	end

	assign o_dm_strb = request ? lane_strb : 4'b0000;

	// Move the addressed byte or halfword down to bit 0
	assign lane_data = i_dm_rdata >> {offset, 3'b000};

	always_comb begin
		case (i_funct3)
			3'b000:  o_load_data = {{24{lane_data[7]}}, lane_data[7:0]};
			3'b001:  o_load_data = {{16{lane_data[15]}}, lane_data[15:0]};
			3'b100:  o_load_data = {24'h000000, lane_data[7:0]};
			3'b101:  o_load_data = {16'h0000, lane_data[15:0]};
			default: o_load_data = i_dm_rdata;
		endcase
	end

	// Hold the core until memory answers
	assign o_stall = request && !i_dm_ready;

endmodule

//--- design/alu.sv
// alu: arithmetic, logic, shift and compare operations plus the branch condition
`timescale 1ns/10ps

module alu (
	input  arvi_pkg::word_t   i_a,
	input  arvi_pkg::word_t   i_b,
	input  arvi_pkg::alu_op_t i_op,
	input  logic [2:0]        i_funct3,
	output arvi_pkg::word_t   o_result,
	output logic              o_branch_taken
);
	import arvi_pkg::*;

	logic       equal;
	logic       less_signed;
	logic       less_unsigned;
	logic [4:0] shamt;

	assign equal         = (i_a == i_b);
	assign less_signed   = ($signed(i_a) < $signed(i_b));
	assign less_unsigned = (i_a < i_b);
	assign shamt         = i_b[4:0];

	always_comb begin
		case (i_op)
			alu_sub:  o_result = i_a - i_b;
			alu_sll:  o_result = i_a << shamt;
			alu_slt:  o_result = {{(xlen-1){1'b0}}, less_signed};
			alu_sltu: o_result = {{(xlen-1){1'b0}}, less_unsigned};
			alu_xor:  o_result = i_a ^ i_b;
			alu_srl:  o_result = i_a >> shamt;
			alu_sra:  o_result = word_t'($signed(i_a) >>> shamt);
			alu_or:   o_result = i_a | i_b;
			alu_and:  o_result = i_a & i_b;
			default:  o_result = i_a + i_b;
		endcase
	end

	// Branch condition from funct3, gated by the branch flag outside
	always_comb begin
		case (i_funct3)
			3'b000:  o_branch_taken = equal;
			3'b001:  o_branch_taken = !equal;
			3'b100:  o_branch_taken = less_signed;
			3'b101:  o_branch_taken = !less_signed;
			3'b110:  o_branch_taken = less_unsigned;
			3'b111:  o_branch_taken = !less_unsigned;
			default: o_branch_taken = 1'b0;
		endcase
	end

endmodule

//--- design/imm_gen.sv
// imm_gen: immediate extraction with sign extension for I, S, B, U and J formats
`timescale 1ns/10ps

module imm_gen (
	input  arvi_pkg::word_t i_instr,
	output arvi_pkg::word_t o_imm
);
	import arvi_pkg::*;

	logic sign;

	assign sign = i_instr[31];

	always_comb begin
		case (i_instr[6:0])
			op_imm, op_load, op_jalr: begin
				o_imm = {{20{sign}}, i_instr[31:20]};
			end
			op_store: begin
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			end
			// B and J come out as byte offsets, bit 0 is zero
			op_branch: begin
				o_imm = {{20{sign}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			end
			op_jal: begin
				o_imm = {{12{sign}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			end
			op_lui, op_auipc: begin
				o_imm = {i_instr[31:12], 12'h000};
			end
			default: o_imm = '0;
		endcase
	end

endmodule

//--- design/reg_file.sv
// reg_file: 32 x 32-bit register file, two combinational reads, one write, x0 hardwired
`timescale 1ns/10ps

module reg_file (
	input  logic            i_clk,
	input  logic            i_rst,
	input  logic [4:0]      i_rs1,
	input  logic [4:0]      i_rs2,
	input  logic [4:0]      i_rd,
	input  logic            i_we,
	input  arvi_pkg::word_t i_wdata,
	output arvi_pkg::word_t o_rdata1,
	output arvi_pkg::word_t o_rdata2
);
	import arvi_pkg::*;

	// x1 to x31, x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we && (i_rd != 5'd0)) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

//--- design/main_control.sv
// main_control: opcode and function field decoder producing the datapath control levels
`timescale 1ns/10ps

module main_control (
	input  arvi_pkg::word_t   i_instr,
	output arvi_pkg::alu_op_t o_alu_op,
	output arvi_pkg::src_a_t  o_src_a,
	output logic              o_src_b_imm,
	output logic              o_reg_write,
	output logic              o_mem_read,
	output logic              o_mem_write,
	output logic              o_branch,
	output arvi_pkg::jump_t   o_jump,
	output arvi_pkg::wb_sel_t o_wb_sel
);
	import arvi_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       funct7_b5;

	assign opcode    = i_instr[6:0];
	assign funct3    = i_instr[14:12];
	assign funct7_b5 = i_instr[30];

	// funct3 selects the operation, alt picks sub or sra
	function automatic alu_op_t decode_alu_op(input logic [2:0] f3, input logic alt);
		alu_op_t op;
		case (f3)
			3'b000:  op = alt ? alu_sub : alu_add;
			3'b001:  op = alu_sll;
			3'b010:  op = alu_slt;
			3'b011:  op = alu_sltu;
			3'b100:  op = alu_xor;
			3'b101:  op = alt ? alu_sra : alu_srl;
			3'b110:  op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	always_comb begin
		// Default is a NOP with nothing written
		o_alu_op    = alu_add;
		o_src_a     = src_a_rs1;
		o_src_b_imm = 1'b0;
		o_reg_write = 1'b0;
		o_mem_read  = 1'b0;
		o_mem_write = 1'b0;
		o_branch    = 1'b0;
		o_jump      = jump_none;
		o_wb_sel    = wb_alu;
		case (opcode)
			op_lui: begin
				o_src_a     = src_a_zero;
				o_src_b_imm = 1'b1;
				o_reg_write = 1'b1;
			end
			op_auipc: begin
				o_src_a     = src_a_pc;
				o_src_b_imm = 1'b1;
				o_reg_write = 1'b1;
			end
			op_jal: begin
				o_jump      = jump_jal;
				o_reg_write = 1'b1;
				o_wb_sel    = wb_pc_plus4;
			end
			op_jalr: begin
				// Target is rs1 + imm from the ALU
				o_jump      = jump_jalr;
				o_src_b_imm = 1'b1;
				o_reg_write = 1'b1;
				o_wb_sel    = wb_pc_plus4;
			end
			op_branch: begin
				o_branch = 1'b1;
				o_alu_op = alu_sub;
			end
			op_load: begin
				o_src_b_imm = 1'b1;
				o_mem_read  = 1'b1;
				o_reg_write = 1'b1;
				o_wb_sel    = wb_mem;
			end
			op_store: begin
				o_src_b_imm = 1'b1;
				o_mem_write = 1'b1;
			end
			op_imm: begin
				// Only srai uses funct7 bit 5, addi has no subtract form
				o_alu_op    = decode_alu_op(funct3, (funct3 == 3'b101) && funct7_b5);
				o_src_b_imm = 1'b1;
				o_reg_write = 1'b1;
			end
			op_reg: begin
				o_alu_op    = decode_alu_op(funct3, funct7_b5);
				o_reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

//--- design/arvi_pkg.sv
// Word width, reset PC, opcodes, ALU operations, selector encodings and strobe type
package arvi_pkg;

	// Datapath word
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;

	// Program counter after reset
	localparam word_t pc_reset = 32'h0000_0000;

	// RV32I base opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_t;

	// Operand A source
	typedef enum logic [1:0] {
		src_a_rs1,
		src_a_pc,
		src_a_zero
	} src_a_t;

	// Register write-back source
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc_plus4
	} wb_sel_t;

	// Unconditional control flow kind
	typedef enum logic [1:0] {
		jump_none,
		jump_jal,
		jump_jalr
	} jump_t;

	// One enable per byte lane
	typedef logic [3:0] strobe_t;

endpackage
